//--- project.f
verilog/cache_dma_pkg.sv
verilog/dma_status_if.sv
verilog/dma_beat_fifo.sv
verilog/dma_req_issue.sv
verilog/dma_refill_path.sv
verilog/dma_evict_path.sv
verilog/dma_done_tracker.sv
verilog/cache_dma.sv
tests/cache_dma_tb.sv

//--- tests/cache_dma_tb.sv
`default_nettype none

module cache_dma_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import cache_dma_pkg::*;

  localparam int beat_width_lp = 64;
  localparam int beat_bytes_lp = beat_width_lp / 8;
  localparam int burst_lp = 4;
  localparam int block_bytes_lp = 32;
  localparam int num_tests_lp = 8;
  localparam int timeout_cycles_lp = num_tests_lp * burst_lp * 20;

  logic                     clk_i = 1'b0;
  logic                     reset_i;
  dma_cmd_e                 mhu_cmd_i;
  logic [31:0]              mhu_req_addr_i;
  logic [1:0]               mhu_req_mshr_id_i;
  logic [7:0]               dirty_word_mask_i;
  logic                     dma_pkt_v_o;
  logic                     dma_pkt_yumi_i;
  logic                     dma_pkt_write_not_read_o;
  logic [31:0]              dma_pkt_addr_o;
  logic [7:0]               dma_pkt_mask_o;
  logic [1:0]               dma_pkt_mshr_id_o;
  logic [63:0]              dma_data_i;
  logic                     dma_data_v_i;
  logic                     dma_data_ready_o;
  logic [1:0]               dma_refill_mshr_id_i;
  logic [255:0]             mshr_data_i;
  logic [31:0]              mshr_byte_mask_i;
  logic                     mshr_cam_r_v_o;
  logic [1:0][63:0]         transmitter_refill_data_o;
  logic                     transmitter_refill_v_o;
  logic                     transmitter_refill_ready_i;
  logic                     transmitter_refill_done_i;
  logic                     transmitter_evict_v_i;
  logic [63:0]              transmitter_evict_data_i;
  logic [1:0]               transmitter_evict_mshr_id_i;
  logic                     transmitter_evict_yumi_o;
  logic [63:0]              dma_data_o;
  logic                     dma_data_v_o;
  logic                     dma_data_yumi_i;
  logic [3:0]               mhu_dma_done_o;

  // expectations shared between stimulus and the compare process
  logic                     exp_pkt_v = 1'b0;
  logic                     exp_pkt_wnr = 1'b0;
  logic [31:0]              exp_pkt_addr = '0;
  logic [7:0]               exp_pkt_mask = '0;
  logic [1:0]               exp_pkt_id = '0;
  logic [3:0]               exp_done = '0;
  logic [127:0]             exp_pair_q[$];
  logic [63:0]              exp_evict_q[$];
  int                       cam_count = 0;
  int                       blocks_sent = 0;
  int                       value_errors = 0;
  int                       other_errors = 0;
  logic [31:0]              lfsr_r = 32'd94398;

  cache_dma dut (.*);

  always #20 clk_i = ~clk_i;

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [255:0] draw_bits(input int n);
    logic [255:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[254:0], lfsr_r[0]};
      lfsr_r = lfsr_step(lfsr_r);
    end
    return r;
  endfunction

  // bytes with a set mask bit come from the MSHR, the rest from memory
  function automatic logic [63:0] merged_beat(input logic [63:0] mem_beat,
                                              input logic [63:0] mshr_beat,
                                              input logic [7:0]  byte_mask);
    logic [63:0] r;
    for (int b = 0; b < beat_bytes_lp; b++) begin
      r[b*8 +: 8] = byte_mask[b] ? mshr_beat[b*8 +: 8] : mem_beat[b*8 +: 8];
    end
    return r;
  endfunction

  task automatic compare_value(input string name, input logic [255:0] expected,
                               input logic [255:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  task automatic report_problem(input string msg);
    other_errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  always @(posedge clk_i) begin : compare_outputs
    logic [127:0] pair;
    if (!reset_i) begin
      compare_value("dma_pkt_v_o", exp_pkt_v, dma_pkt_v_o);
      if (exp_pkt_v) begin
        compare_value("dma_pkt_write_not_read_o", exp_pkt_wnr, dma_pkt_write_not_read_o);
        compare_value("dma_pkt_addr_o", exp_pkt_addr, dma_pkt_addr_o);
        compare_value("dma_pkt_mask_o", exp_pkt_mask, dma_pkt_mask_o);
        compare_value("dma_pkt_mshr_id_o", exp_pkt_id, dma_pkt_mshr_id_o);
      end
      compare_value("mhu_dma_done_o", exp_done, mhu_dma_done_o);
      if (mshr_cam_r_v_o) begin
        cam_count++;
      end
      if (transmitter_refill_v_o && transmitter_refill_ready_i) begin
        if (exp_pair_q.size() == 0) begin
          report_problem("refill pair sent while none was expected");
        end else begin
          pair = exp_pair_q.pop_front();
          compare_value("transmitter_refill_data_o", pair, transmitter_refill_data_o);
        end
      end
      if (dma_data_v_o && dma_data_yumi_i) begin
        if (exp_evict_q.size() == 0) begin
          report_problem("evict beat sent to memory while none was expected");
        end else begin
          compare_value("dma_data_o", exp_evict_q.pop_front(), dma_data_o);
        end
      end
    end
  end

  task automatic run_request(input dma_cmd_e cmd);
    logic [31:0] addr;
    logic [1:0]  id;
    logic [7:0]  dirty;
    int          hold;
    addr  = draw_bits(32);
    id    = draw_bits(2);
    dirty = draw_bits(8);
    hold  = 1 + int'(draw_bits(2));
    @(negedge clk_i);
    mhu_cmd_i         = cmd;
    mhu_req_addr_i    = addr;
    mhu_req_mshr_id_i = id;
    dirty_word_mask_i = dirty;
    exp_pkt_v         = (cmd != e_dma_nop);
    exp_pkt_wnr       = (cmd == e_dma_send_evict_addr);
    exp_pkt_addr      = addr & ~32'(block_bytes_lp - 1);
    exp_pkt_mask      = exp_pkt_wnr ? dirty : 8'h00;
    exp_pkt_id        = id;
    repeat (hold) @(negedge clk_i);
    if (exp_pkt_v) begin
      dma_pkt_yumi_i = 1'b1;
      exp_done       = 4'(1 << id);
      @(negedge clk_i);
      dma_pkt_yumi_i = 1'b0;
      exp_done       = '0;
    end
    mhu_cmd_i = e_dma_nop;
    exp_pkt_v = 1'b0;
  endtask

  task automatic feed_refill_beats(input logic [255:0] blk);
    int k;
    k = 0;
    while (k < burst_lp) begin
      @(negedge clk_i);
      dma_data_v_i = (draw_bits(2) != 0);
      dma_data_i   = blk[k*beat_width_lp +: beat_width_lp];
      @(posedge clk_i);
      if (dma_data_v_i && dma_data_ready_o) begin
        k++;
      end
    end
    @(negedge clk_i);
    dma_data_v_i = 1'b0;
  endtask

  task automatic drain_refill_pairs();
    while (exp_pair_q.size() != 0) begin
      @(negedge clk_i);
      transmitter_refill_ready_i = draw_bits(1);
    end
    transmitter_refill_ready_i = 1'b0;
  endtask

  task automatic run_refill_block(input logic [1:0] id, input bit hold_back);
    logic [255:0] mem_block;
    logic [255:0] mshr_block;
    logic [31:0]  mshr_mask;
    logic [63:0]  lo;
    logic [63:0]  hi;
    int           waited;
    mem_block  = draw_bits(256);
    mshr_block = draw_bits(256);
    mshr_mask  = draw_bits(32);
    for (int p = 0; p < burst_lp / 2; p++) begin
      lo = merged_beat(mem_block[2*p*beat_width_lp +: beat_width_lp],
                       mshr_block[2*p*beat_width_lp +: beat_width_lp],
                       mshr_mask[2*p*beat_bytes_lp +: beat_bytes_lp]);
      hi = merged_beat(mem_block[(2*p+1)*beat_width_lp +: beat_width_lp],
                       mshr_block[(2*p+1)*beat_width_lp +: beat_width_lp],
                       mshr_mask[(2*p+1)*beat_bytes_lp +: beat_bytes_lp]);
      exp_pair_q.push_back({hi, lo});
    end
    @(negedge clk_i);
    dma_refill_mshr_id_i = id;
    mshr_data_i          = mshr_block;
    mshr_byte_mask_i     = mshr_mask;
    if (hold_back) begin
      transmitter_refill_ready_i = 1'b0;
      feed_refill_beats(mem_block);
      waited = 0;
      while (dma_data_ready_o && waited < 20) begin
        @(negedge clk_i);
        waited++;
      end
      if (dma_data_ready_o) begin
        report_problem("dma_data_ready_o stayed high under back-pressure");
      end
      // the held pair must be the first one of the block
      compare_value("transmitter_refill_data_o", exp_pair_q[0], transmitter_refill_data_o);
      compare_value("transmitter_refill_v_o", 1'b1, transmitter_refill_v_o);
      drain_refill_pairs();
    end else begin
      fork
        feed_refill_beats(mem_block);
        drain_refill_pairs();
      join
    end
    blocks_sent++;
    compare_value("mshr_cam_r_v_o pulses", blocks_sent, cam_count);
    // transmitter reports the block written into the data array
    @(negedge clk_i);
    transmitter_refill_done_i = 1'b1;
    exp_done                  = 4'(1 << id);
    @(negedge clk_i);
    transmitter_refill_done_i = 1'b0;
    exp_done                  = '0;
  endtask

  task automatic run_evict_block(input logic [1:0] id);
    logic [255:0] blk;
    int           k;
    int           n;
    blk = draw_bits(256);
    for (int b = 0; b < burst_lp; b++) begin
      exp_evict_q.push_back(blk[b*beat_width_lp +: beat_width_lp]);
    end
    k = 0;
    while (k < burst_lp) begin
      @(negedge clk_i);
      transmitter_evict_v_i       = (draw_bits(2) != 0);
      transmitter_evict_data_i    = blk[k*beat_width_lp +: beat_width_lp];
      // only the first beat's id counts
      transmitter_evict_mshr_id_i = (k == 0) ? id : 2'(draw_bits(2));
      @(posedge clk_i);
      compare_value("dma_data_v_o", 1'b0, dma_data_v_o);
      compare_value("transmitter_evict_yumi_o", transmitter_evict_v_i,
                    transmitter_evict_yumi_o);
      if (transmitter_evict_yumi_o) begin
        k++;
      end
    end
    n = 0;
    while (n < burst_lp) begin
      @(negedge clk_i);
      transmitter_evict_v_i = 1'b0;
      dma_data_yumi_i       = dma_data_v_o & draw_bits(1);
      @(posedge clk_i);
      if (dma_data_yumi_i) begin
        n++;
      end
    end
    @(negedge clk_i);
    dma_data_yumi_i = 1'b0;
    exp_done        = 4'(1 << id);
    @(negedge clk_i);
    exp_done        = '0;
  endtask

  initial begin
    reset_i                     = 1'b1;
    mhu_cmd_i                   = e_dma_nop;
    mhu_req_addr_i              = '0;
    mhu_req_mshr_id_i           = '0;
    dirty_word_mask_i           = '0;
    dma_pkt_yumi_i              = 1'b0;
    dma_data_i                  = '0;
    dma_data_v_i                = 1'b0;
    dma_refill_mshr_id_i        = '0;
    mshr_data_i                 = '0;
    mshr_byte_mask_i            = '0;
    transmitter_refill_ready_i  = 1'b0;
    transmitter_refill_done_i   = 1'b0;
    transmitter_evict_v_i       = 1'b0;
    transmitter_evict_data_i    = '0;
    transmitter_evict_mshr_id_i = '0;
    dma_data_yumi_i             = 1'b0;
    repeat (2) @(negedge clk_i);
    reset_i = 1'b0;

    // idle state right out of reset
    compare_value("transmitter_refill_v_o", 1'b0, transmitter_refill_v_o);
    compare_value("dma_data_v_o", 1'b0, dma_data_v_o);
    compare_value("mshr_cam_r_v_o", 1'b0, mshr_cam_r_v_o);
    compare_value("mhu_dma_done_o", 4'h0, mhu_dma_done_o);
    compare_value("dma_data_ready_o", 1'b1, dma_data_ready_o);

    run_request(e_dma_send_refill_addr);
    run_request(e_dma_send_evict_addr);
    run_request(e_dma_nop);
    run_refill_block(2'(draw_bits(2)), 1'b0);
    run_refill_block(2'(draw_bits(2)), 1'b0);
    run_evict_block(2'(draw_bits(2)));
    run_evict_block(2'(draw_bits(2)));
    run_refill_block(2'(draw_bits(2)), 1'b1);
    repeat (3) @(negedge clk_i);

    if (exp_pair_q.size() != 0 || exp_evict_q.size() != 0) begin
      report_problem("expected beats were never seen at the outputs");
    end
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    repeat (timeout_cycles_lp) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", timeout_cycles_lp);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/cache_dma.sv
`default_nettype none

module cache_dma #(
  parameter int addr_width_p = 32,
  parameter int word_width_p = 32,
  parameter int block_size_in_words_p = 8,
  parameter int dma_data_width_p = 64,
  parameter int mshr_els_p = 4,
  localparam int lg_mshr_els_lp = (mshr_els_p > 1) ? $clog2(mshr_els_p) : 1,
  localparam int block_data_width_lp = block_size_in_words_p * word_width_p,
  localparam int block_mask_width_lp = block_data_width_lp / cache_dma_pkg::byte_width_c
) (
  input  logic                             clk_i,
  input  logic                             reset_i,

  // request side, from the miss handling unit
  input  cache_dma_pkg::dma_cmd_e          mhu_cmd_i,
  input  logic [addr_width_p-1:0]          mhu_req_addr_i,
  input  logic [lg_mshr_els_lp-1:0]        mhu_req_mshr_id_i,
  input  logic [block_size_in_words_p-1:0] dirty_word_mask_i,
  output logic                             dma_pkt_v_o,
  input  logic                             dma_pkt_yumi_i,
  output logic                             dma_pkt_write_not_read_o,
  output logic [addr_width_p-1:0]          dma_pkt_addr_o,
  output logic [block_size_in_words_p-1:0] dma_pkt_mask_o,
  output logic [lg_mshr_els_lp-1:0]        dma_pkt_mshr_id_o,

  // refill side
  input  logic [dma_data_width_p-1:0]      dma_data_i,
  input  logic                             dma_data_v_i,
  output logic                             dma_data_ready_o,
  input  logic [lg_mshr_els_lp-1:0]        dma_refill_mshr_id_i,
  input  logic [block_data_width_lp-1:0]   mshr_data_i,
  input  logic [block_mask_width_lp-1:0]   mshr_byte_mask_i,
  output logic                             mshr_cam_r_v_o,
  output logic [1:0][dma_data_width_p-1:0] transmitter_refill_data_o,
  output logic                             transmitter_refill_v_o,
  input  logic                             transmitter_refill_ready_i,
  input  logic                             transmitter_refill_done_i,

  // evict side
  input  logic                             transmitter_evict_v_i,
  input  logic [dma_data_width_p-1:0]      transmitter_evict_data_i,
  input  logic [lg_mshr_els_lp-1:0]        transmitter_evict_mshr_id_i,
  output logic                             transmitter_evict_yumi_o,
  output logic [dma_data_width_p-1:0]      dma_data_o,
  output logic                             dma_data_v_o,
  input  logic                             dma_data_yumi_i,

  output logic [mshr_els_p-1:0]            mhu_dma_done_o
);

  // completion events of all three engines meet here
  dma_status_if #(.mshr_els_p(mshr_els_p)) status (
    .clk_i(clk_i),
    .reset_i(reset_i)
  );

  dma_req_issue #(
    .addr_width_p(addr_width_p),
    .word_width_p(word_width_p),
    .block_size_in_words_p(block_size_in_words_p),
    .mshr_els_p(mshr_els_p)
  ) req_issue (.*);

  dma_refill_path #(
    .word_width_p(word_width_p),
    .block_size_in_words_p(block_size_in_words_p),
    .dma_data_width_p(dma_data_width_p),
    .mshr_els_p(mshr_els_p)
  ) refill_path (.*);

  dma_evict_path #(
    .word_width_p(word_width_p),
    .block_size_in_words_p(block_size_in_words_p),
    .dma_data_width_p(dma_data_width_p),
    .mshr_els_p(mshr_els_p)
  ) evict_path (.*);

  dma_done_tracker #(
    .mshr_els_p(mshr_els_p)
  ) done_tracker (.*);

endmodule

`default_nettype wire

//--- verilog/cache_dma_pkg.sv
`default_nettype none

package cache_dma_pkg;

  // what the miss handling unit asks the DMA engine to do
  typedef enum logic [1:0] {
    e_dma_nop              = 2'b00,
    e_dma_send_refill_addr = 2'b01,
    e_dma_send_evict_addr  = 2'b10
  } dma_cmd_e;

  // bits in one byte lane of a byte mask
  localparam int byte_width_c = 8;

  // smallest depth for any beat FIFO
  localparam int min_fifo_els_c = 2;

endpackage

`default_nettype wire

//--- verilog/dma_beat_fifo.sv
`default_nettype none

module dma_beat_fifo #(
  parameter int width_p = 64,
  parameter int els_p = 4,
  localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1,
  localparam int count_width_lp = $clog2(els_p + 1)
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               v_i,
  output logic               ready_o,
  input  logic [width_p-1:0] data_i,
  output logic               v_o,
  output logic [width_p-1:0] data_o,
  input  logic               yumi_i
);

  logic [width_p-1:0]        mem_r [els_p];
  logic [ptr_width_lp-1:0]   rd_ptr_r;
  logic [ptr_width_lp-1:0]   wr_ptr_r;
  logic [count_width_lp-1:0] count_r;
  logic                      enq;
  logic                      deq;

  assign ready_o = (count_r < els_p);
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];
  assign enq     = v_i & ready_o;
  assign deq     = yumi_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      // pointers wrap at the last entry, so any depth works
      if (enq) begin
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (deq) begin
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      if (enq && !deq) begin
        count_r <= count_r + 1'b1;
      end else if (!enq && deq) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  // consumer may only take a beat that is on offer
  assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o)
    else $error("yumi_i without v_o in beat fifo");

endmodule

`default_nettype wire

//--- verilog/dma_done_tracker.sv
`default_nettype none

module dma_done_tracker #(
  parameter int mshr_els_p = 4
) (
  dma_status_if.tracker          status,
  output logic [mshr_els_p-1:0] mhu_dma_done_o
);

  logic [mshr_els_p-1:0] req_oh;
  logic [mshr_els_p-1:0] refill_oh;
  logic [mshr_els_p-1:0] evict_oh;

  // one-hot per engine
  always_comb begin
    for (int i = 0; i < mshr_els_p; i++) begin
      req_oh[i]    = status.req_done & (status.req_id == i);
      refill_oh[i] = status.refill_done & (status.refill_id == i);
      evict_oh[i]  = status.evict_done & (status.evict_id == i);
    end
  end

  assign mhu_dma_done_o = req_oh | refill_oh | evict_oh;

  // the MHU frees an entry on done, so two engines must never finish the same one together
  assert property (@(posedge status.clk_i) disable iff (status.reset_i)
    ((req_oh & refill_oh) | (req_oh & evict_oh) | (refill_oh & evict_oh)) == '0)
    else $error("two completions for one mshr entry in the same cycle");

endmodule

`default_nettype wire

//--- verilog/dma_evict_path.sv
`default_nettype none

module dma_evict_path #(
  parameter int word_width_p = 32,
  parameter int block_size_in_words_p = 8,
  parameter int dma_data_width_p = 64,
  parameter int mshr_els_p = 4,
  localparam int lg_mshr_els_lp = (mshr_els_p > 1) ? $clog2(mshr_els_p) : 1
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        transmitter_evict_v_i,
  input  logic [dma_data_width_p-1:0] transmitter_evict_data_i,
  input  logic [lg_mshr_els_lp-1:0]   transmitter_evict_mshr_id_i,
  output logic                        transmitter_evict_yumi_o,
  output logic [dma_data_width_p-1:0] dma_data_o,
  output logic                        dma_data_v_o,
  input  logic                        dma_data_yumi_i,
  dma_status_if.evict                 status
);
  import cache_dma_pkg::*;

  localparam int burst_lp = block_size_in_words_p * word_width_p / dma_data_width_p;
  localparam int cnt_width_lp = $clog2(burst_lp + 1);
  localparam int fifo_els_lp = (burst_lp < min_fifo_els_c) ? min_fifo_els_c : burst_lp;

  logic [cnt_width_lp-1:0]   in_cnt_r;
  logic                      in_full;
  logic                      accept;
  logic                      fifo_ready_lo;
  logic                      fifo_v_lo;
  logic                      evict_done;
  logic [lg_mshr_els_lp-1:0] evict_id_r;

  assign in_full                  = (in_cnt_r == burst_lp);
  assign accept                   = transmitter_evict_v_i & fifo_ready_lo & ~in_full;
  assign transmitter_evict_yumi_o = accept;

  dma_beat_fifo #(
    .width_p(dma_data_width_p),
    .els_p(fifo_els_lp)
  ) out_fifo (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .v_i(accept),
    .ready_o(fifo_ready_lo),
    .data_i(transmitter_evict_data_i),
    .v_o(fifo_v_lo),
    .data_o(dma_data_o),
    .yumi_i(dma_data_yumi_i)
  );

  // memory sees nothing until the whole block is buffered
  assign dma_data_v_o = fifo_v_lo & in_full;

  // block is gone once everything came in and the fifo ran dry
  assign evict_done = in_full & ~fifo_v_lo;

  always_ff @(posedge clk_i) begin
    if (reset_i || evict_done) begin
      in_cnt_r <= '0;
    end else if (accept) begin
      in_cnt_r <= in_cnt_r + 1'b1;
    end
  end

  // id rides along with the first beat
  always_ff @(posedge clk_i) begin
    if (accept && (in_cnt_r == '0)) begin
      evict_id_r <= transmitter_evict_mshr_id_i;
    end
  end

  assign status.evict_done = evict_done;
  assign status.evict_id   = evict_id_r;

endmodule

`default_nettype wire

//--- verilog/dma_refill_path.sv
`default_nettype none

module dma_refill_path #(
  parameter int word_width_p = 32,
  parameter int block_size_in_words_p = 8,
  parameter int dma_data_width_p = 64,
  parameter int mshr_els_p = 4,
  localparam int lg_mshr_els_lp = (mshr_els_p > 1) ? $clog2(mshr_els_p) : 1,
  localparam int block_data_width_lp = block_size_in_words_p * word_width_p,
  localparam int block_mask_width_lp = block_data_width_lp / cache_dma_pkg::byte_width_c
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic [dma_data_width_p-1:0]      dma_data_i,
  input  logic                             dma_data_v_i,
  output logic                             dma_data_ready_o,
  input  logic [lg_mshr_els_lp-1:0]        dma_refill_mshr_id_i,
  input  logic [block_data_width_lp-1:0]   mshr_data_i,
  input  logic [block_mask_width_lp-1:0]   mshr_byte_mask_i,
  output logic                             mshr_cam_r_v_o,
  output logic [1:0][dma_data_width_p-1:0] transmitter_refill_data_o,
  output logic                             transmitter_refill_v_o,
  input  logic                             transmitter_refill_ready_i,
  input  logic                             transmitter_refill_done_i,
  dma_status_if.refill                     status
);
  import cache_dma_pkg::*;

  localparam int burst_lp = block_data_width_lp / dma_data_width_p;
  localparam int cnt_width_lp = $clog2(burst_lp + 1);
  localparam int sel_width_lp = (burst_lp > 1) ? $clog2(burst_lp) : 1;
  localparam int beat_mask_width_lp = dma_data_width_p / byte_width_c;
  localparam int fifo_els_lp = (burst_lp < min_fifo_els_c) ? min_fifo_els_c : burst_lp;

  logic [cnt_width_lp-1:0]          in_cnt_r;
  logic [cnt_width_lp-1:0]          out_cnt_r;
  logic                             in_full;
  logic                             fifo_v_li;
  logic                             fifo_ready_lo;
  logic                             accept;
  logic                             fifo_v_lo;
  logic [dma_data_width_p-1:0]      fifo_data_lo;
  logic                             fifo_yumi_li;
  logic [lg_mshr_els_lp-1:0]        refill_id_r;
  logic [block_data_width_lp-1:0]   mshr_data_r;
  logic [block_mask_width_lp-1:0]   mshr_mask_r;
  logic [sel_width_lp-1:0]          beat_sel;
  logic [dma_data_width_p-1:0]      mshr_beat;
  logic [beat_mask_width_lp-1:0]    mshr_beat_mask;
  logic [dma_data_width_p-1:0]      merged_beat;
  logic [1:0][dma_data_width_p-1:0] pair_r;
  logic [1:0]                       pair_cnt_r;
  logic                             pair_full;
  logic                             pair_yumi;
  logic                             done_r;
  logic                             done_seen;
  logic                             refill_done;

  // pairing into two-beat words needs an even beat count
  if ((burst_lp % 2) != 0) begin : g_odd_burst
    $error("refill path needs an even number of beats per block");
  end

  // stop taking beats once the whole block is in
  assign in_full          = (in_cnt_r == burst_lp);
  assign fifo_v_li        = dma_data_v_i & ~in_full;
  assign dma_data_ready_o = fifo_ready_lo & ~in_full;
  assign accept           = fifo_v_li & fifo_ready_lo;
  assign mshr_cam_r_v_o   = accept & (in_cnt_r == '0);

  dma_beat_fifo #(
    .width_p(dma_data_width_p),
    .els_p(fifo_els_lp)
  ) in_fifo (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .v_i(fifo_v_li),
    .ready_o(fifo_ready_lo),
    .data_i(dma_data_i),
    .v_o(fifo_v_lo),
    .data_o(fifo_data_lo),
    .yumi_i(fifo_yumi_li)
  );

  // pick the block slice that lines up with the beat leaving the fifo
  assign beat_sel       = out_cnt_r[sel_width_lp-1:0];
  assign mshr_beat      = mshr_data_r[beat_sel*dma_data_width_p +: dma_data_width_p];
  assign mshr_beat_mask = mshr_mask_r[beat_sel*beat_mask_width_lp +: beat_mask_width_lp];

  // bytes already written into the MSHR win over memory data
  always_comb begin
    for (int i = 0; i < beat_mask_width_lp; i++) begin
      merged_beat[i*byte_width_c +: byte_width_c] = mshr_beat_mask[i]
        ? mshr_beat[i*byte_width_c +: byte_width_c]
        : fifo_data_lo[i*byte_width_c +: byte_width_c];
    end
  end

  assign pair_full                 = pair_cnt_r[1];
  assign fifo_yumi_li              = fifo_v_lo & ~pair_full;
  assign transmitter_refill_v_o    = pair_full;
  assign transmitter_refill_data_o = pair_r;
  assign pair_yumi                 = pair_full & transmitter_refill_ready_i;

  // a done pulse may come early, so the flag holds it until all beats are in
  assign done_seen   = done_r | transmitter_refill_done_i;
  assign refill_done = in_full & done_seen;

  always_ff @(posedge clk_i) begin
    if (reset_i || refill_done) begin
      in_cnt_r  <= '0;
      out_cnt_r <= '0;
      done_r    <= 1'b0;
    end else begin
      if (accept) begin
        in_cnt_r <= in_cnt_r + 1'b1;
      end
      if (fifo_yumi_li) begin
        out_cnt_r <= out_cnt_r + 1'b1;
      end
      if (transmitter_refill_done_i) begin
        done_r <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pair_cnt_r <= '0;
    end else if (pair_yumi) begin
      pair_cnt_r <= '0;
    end else if (fifo_yumi_li) begin
      pair_cnt_r <= pair_cnt_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mshr_cam_r_v_o) begin
      refill_id_r <= dma_refill_mshr_id_i;
      mshr_data_r <= mshr_data_i;
      mshr_mask_r <= mshr_byte_mask_i;
    end
    if (fifo_yumi_li) begin
      pair_r[pair_cnt_r[0]] <= merged_beat;
    end
  end

  assign status.refill_done = refill_done;
  assign status.refill_id   = refill_id_r;

  assert property (@(posedge clk_i) disable iff (reset_i) in_cnt_r <= burst_lp)
    else $error("refill beat count ran past the block");

endmodule

`default_nettype wire

//--- verilog/dma_req_issue.sv
`default_nettype none

module dma_req_issue #(
  parameter int addr_width_p = 32,
  parameter int word_width_p = 32,
  parameter int block_size_in_words_p = 8,
  parameter int mshr_els_p = 4,
  localparam int lg_mshr_els_lp = (mshr_els_p > 1) ? $clog2(mshr_els_p) : 1
) (
  input  cache_dma_pkg::dma_cmd_e          mhu_cmd_i,
  input  logic [addr_width_p-1:0]          mhu_req_addr_i,
  input  logic [lg_mshr_els_lp-1:0]        mhu_req_mshr_id_i,
  input  logic [block_size_in_words_p-1:0] dirty_word_mask_i,
  output logic                             dma_pkt_v_o,
  input  logic                             dma_pkt_yumi_i,
  output logic                             dma_pkt_write_not_read_o,
  output logic [addr_width_p-1:0]          dma_pkt_addr_o,
  output logic [block_size_in_words_p-1:0] dma_pkt_mask_o,
  output logic [lg_mshr_els_lp-1:0]        dma_pkt_mshr_id_o,
  dma_status_if.req                        status
);
  import cache_dma_pkg::*;

  localparam int block_bytes_lp = block_size_in_words_p * word_width_p / byte_width_c;
  localparam int block_offset_width_lp = (block_bytes_lp > 1) ? $clog2(block_bytes_lp) : 0;
  localparam logic [addr_width_p-1:0] offset_mask_lp = (1 << block_offset_width_lp) - 1;

  always_comb begin
    dma_pkt_v_o              = 1'b0;
    dma_pkt_write_not_read_o = 1'b0;
    dma_pkt_mask_o           = '0;
    case (mhu_cmd_i)
      e_dma_send_refill_addr: begin
        dma_pkt_v_o = 1'b1;
      end
      e_dma_send_evict_addr: begin
        dma_pkt_v_o              = 1'b1;
        dma_pkt_write_not_read_o = 1'b1;
        // only dirty words go back to memory
        dma_pkt_mask_o           = dirty_word_mask_i;
      end
      default: begin
        dma_pkt_v_o = 1'b0;
      end
    endcase
  end

  // requests are always block aligned
  assign dma_pkt_addr_o    = mhu_req_addr_i & ~offset_mask_lp;
  assign dma_pkt_mshr_id_o = mhu_req_mshr_id_i;

  assign status.req_done = dma_pkt_v_o & dma_pkt_yumi_i;
  assign status.req_id   = mhu_req_mshr_id_i;

endmodule

`default_nettype wire

//--- verilog/dma_status_if.sv
`default_nettype none

interface dma_status_if #(
  parameter int mshr_els_p = 4,
  localparam int lg_mshr_els_lp = (mshr_els_p > 1) ? $clog2(mshr_els_p) : 1
) (
  input logic clk_i,
  input logic reset_i
);

  // one completion event per engine, each tagged with its MSHR entry
  logic                      req_done;
  logic [lg_mshr_els_lp-1:0] req_id;
  logic                      refill_done;
  logic [lg_mshr_els_lp-1:0] refill_id;
  logic                      evict_done;
  logic [lg_mshr_els_lp-1:0] evict_id;

  modport req (output req_done, output req_id);
  modport refill (output refill_done, output refill_id);
  modport evict (output evict_done, output evict_id);

  modport tracker (
    input clk_i,
    input reset_i,
    input req_done,
    input req_id,
    input refill_done,
    input refill_id,
    input evict_done,
    input evict_id
  );

endinterface

`default_nettype wire
